// ==== sim.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/hazard_pkg.sv
logic/instr_field_decoder.sv
logic/stall_detector.sv
logic/stage_tracker.sv
logic/forward_select.sv
logic/hazard_unit_top.sv
test/hazard_unit_tb.sv

// ==== Makefile ====
SIM := obj_dir/hazard_unit_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module hazard_unit_tb \
		-f sim.f -o hazard_unit_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== test/hazard_unit_tb.sv ====
`timescale 1ns/100ps

module hazard_unit_tb;

    typedef rv_isa_pkg::reg_idx_t reg_t;
    typedef rv_isa_pkg::instr_t   instr_t;

    // one stimulus step and what the hazard unit should answer
    typedef struct packed {
        instr_t                word;
        logic                  valid;
        // number of stall cycles while this word waits in ID
        logic                  stall;
        // selects for the word accepted just before this one, now in EX
        hazard_pkg::fwd_pair_t fwd;
    } row_t;

    localparam hazard_pkg::fwd_sel_t f_no  = hazard_pkg::fwd_none;
    localparam hazard_pkg::fwd_sel_t f_mem = hazard_pkg::fwd_mem;
    localparam hazard_pkg::fwd_sel_t f_wb  = hazard_pkg::fwd_wb;
    localparam hazard_pkg::fwd_sel_t f_ld  = hazard_pkg::fwd_mem_load;
    localparam int max_hold    = 4;
    localparam int filler_rows = 24;

    logic                  clk;
    logic                  arst_n;
    instr_t                instr_id;
    logic                  instr_valid;
    logic                  stall;
    hazard_pkg::fwd_pair_t fwd;

    row_t  rows[$];
    string names[$];

    hazard_unit_top i_hazard_unit_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_id    (instr_id),
        .instr_valid (instr_valid),
        .stall       (stall),
        .fwd         (fwd)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // add rd, rs1, rs2
    function automatic instr_t enc_r(input reg_t rd, input reg_t rs1, input reg_t rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, rv_isa_pkg::op_op};
    endfunction

    // lw rd, 0(rs1)
    function automatic instr_t enc_lw(input reg_t rd, input reg_t rs1);
        return {12'd0, rs1, 3'b010, rd, rv_isa_pkg::op_load};
    endfunction

    // addi rd, rs1, 1
    function automatic instr_t enc_addi(input reg_t rd, input reg_t rs1);
        return {12'd1, rs1, 3'b000, rd, rv_isa_pkg::op_op_imm};
    endfunction

    // sw rs2, 0(rs1)
    function automatic instr_t enc_sw(input reg_t rs1, input reg_t rs2);
        return {7'd0, rs2, rs1, 3'b010, 5'd0, rv_isa_pkg::op_store};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input string name, input instr_t word, input logic valid,
                           input logic stall_exp, input hazard_pkg::fwd_sel_t rs1_sel,
                           input hazard_pkg::fwd_sel_t rs2_sel);
        row_t r;
        r.word        = word;
        r.valid       = valid;
        r.stall       = stall_exp;
        r.fwd.rs1_sel = rs1_sel;
        r.fwd.rs2_sel = rs2_sel;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic build_table();
        logic [31:0] seed;
        reg_t        rs1;
        reg_t        rs2;
        reg_t        rd;
        instr_t      word;
        add_row("idle", 32'd0, 1'b0, 1'b0, f_no, f_no);
        // load then a dependent add, one bubble, then the add reads from WB
        add_row("ld_x1", enc_lw(5'd1, 5'd2), 1'b1, 1'b0, f_no, f_no);
        add_row("add_use_x1", enc_r(5'd3, 5'd1, 5'd4), 1'b1, 1'b1, f_no, f_no);
        add_row("add_after_stall", enc_r(5'd5, 5'd6, 5'd7), 1'b1, 1'b0, f_wb, f_no);
        add_row("gap_a", 32'd0, 1'b0, 1'b0, f_no, f_no);
        // store data from the load is taken at the memory stage
        add_row("ld_x8", enc_lw(5'd8, 5'd9), 1'b1, 1'b0, f_no, f_no);
        add_row("sw_data_x8", enc_sw(5'd10, 5'd8), 1'b1, 1'b0, f_no, f_no);
        add_row("gap_b", 32'd0, 1'b0, 1'b0, f_no, f_ld);
        // store address from the load has to wait
        add_row("ld_x11", enc_lw(5'd11, 5'd12), 1'b1, 1'b0, f_no, f_no);
        add_row("sw_addr_x11", enc_sw(5'd11, 5'd13), 1'b1, 1'b1, f_no, f_no);
        add_row("gap_c", 32'd0, 1'b0, 1'b0, f_wb, f_no);
        // back to back ALU, then one independent op in between
        add_row("alu_x14", enc_r(5'd14, 5'd1, 5'd2), 1'b1, 1'b0, f_no, f_no);
        add_row("alu_use_x14", enc_r(5'd15, 5'd14, 5'd6), 1'b1, 1'b0, f_no, f_no);
        add_row("alu_indep", enc_addi(5'd4, 5'd6), 1'b1, 1'b0, f_mem, f_no);
        add_row("alu_skip_x15", enc_r(5'd5, 5'd15, 5'd6), 1'b1, 1'b0, f_no, f_no);
        add_row("gap_d", 32'd0, 1'b0, 1'b0, f_wb, f_no);
        // x0 destination is never a producer
        add_row("ld_x0", enc_lw(5'd0, 5'd9), 1'b1, 1'b0, f_no, f_no);
        add_row("add_reads_x0", enc_r(5'd6, 5'd0, 5'd0), 1'b1, 1'b0, f_no, f_no);
        add_row("gap_e", 32'd0, 1'b0, 1'b0, f_no, f_no);
        // consumer word present but not valid
        add_row("ld_x2", enc_lw(5'd2, 5'd3), 1'b1, 1'b0, f_no, f_no);
        add_row("invalid_use_x2", enc_r(5'd7, 5'd2, 5'd2), 1'b0, 1'b0, f_no, f_no);
        add_row("gap_f", 32'd0, 1'b0, 1'b0, f_no, f_no);
        // filler reads x24..x27 and writes x28..x31, so it never depends on itself
        seed = 32'h02e6_ed30;
        for (int n = 0; n < filler_rows; n++) begin
            seed = lcg_next(seed);
            rs1  = {3'b110, seed[31:30]};
            rs2  = {3'b110, seed[29:28]};
            rd   = {3'b111, seed[27:26]};
            case (seed[25:24])
                2'd0: word = enc_lw(rd, rs1);
                2'd1: word = enc_r(rd, rs1, rs2);
                2'd2: word = enc_addi(rd, rs1);
                default: word = enc_sw(rs1, rs2);
            endcase
            add_row($sformatf("filler_%0d", n), word, 1'b1, 1'b0, f_no, f_no);
        end
    endtask

    initial begin
        int stall_cycles;
        instr_id    = '0;
        instr_valid = 1'b0;
        arst_n      = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        // empty pipe right out of reset
        @(negedge clk);
        check_value("reset_stall", 32'd0, {31'b0, stall});
        check_value("reset_fwd", 32'd0, {28'b0, fwd});
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            instr_id    <= rows[i].word;
            instr_valid <= rows[i].valid;
            // sampled mid cycle, away from the driving edge
            @(negedge clk);
            check_value({names[i], "_fwd"}, {28'b0, rows[i].fwd}, {28'b0, fwd});
            // word stays in ID while stall is up
            stall_cycles = 0;
            while (stall) begin
                stall_cycles++;
                if (stall_cycles > max_hold) begin
                    abort_run($sformatf("timeout, stall stuck high on row %s", names[i]));
                end
                @(negedge clk);
            end
            check_value({names[i], "_stall"}, {31'b0, rows[i].stall}, stall_cycles);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== logic/hazard_unit_top.sv ====
`timescale 1ns/100ps

module hazard_unit_top (
    input  logic                  clk,
    input  logic                  arst_n,
    // word held in ID, must stay put while stall is high
    input  rv_isa_pkg::instr_t    instr_id,
    input  logic                  instr_valid,
    output logic                  stall,
    // selects for the word now in EX
    output hazard_pkg::fwd_pair_t fwd
);

    hazard_pkg::stage_rec_t id_rec;
    hazard_pkg::stage_rec_t ex_rec;
    hazard_pkg::stage_rec_t mem_rec;
    hazard_pkg::stage_rec_t wb_rec;

    instr_field_decoder i_instr_field_decoder (
        .instr (instr_id),
        .valid (instr_valid),
        .rec   (id_rec)
    );

    // load-use check against the record one stage ahead
    stall_detector i_stall_detector (
        .id_rec (id_rec),
        .ex_rec (ex_rec),
        .stall  (stall)
    );

    stage_tracker i_stage_tracker (
        .clk     (clk),
        .arst_n  (arst_n),
        .id_rec  (id_rec),
        .stall   (stall),
        .ex_rec  (ex_rec),
        .mem_rec (mem_rec),
        .wb_rec  (wb_rec)
    );

    forward_select i_forward_select (
        .clk     (clk),
        .arst_n  (arst_n),
        .ex_rec  (ex_rec),
        .mem_rec (mem_rec),
        .wb_rec  (wb_rec),
        .fwd     (fwd)
    );

endmodule

// ==== logic/forward_select.sv ====
`timescale 1ns/100ps

module forward_select (
    // only for the checks below
    input  logic                   clk,
    input  logic                   arst_n,
    input  hazard_pkg::stage_rec_t ex_rec,
    input  hazard_pkg::stage_rec_t mem_rec,
    input  hazard_pkg::stage_rec_t wb_rec,
    output hazard_pkg::fwd_pair_t  fwd
);

    logic mem_is_load;
    logic ex_is_store;

    assign mem_is_load = (mem_rec.opcode == rv_isa_pkg::op_load);
    assign ex_is_store = (ex_rec.opcode == rv_isa_pkg::op_store);

    // one operand, youngest producer wins
    function automatic hazard_pkg::fwd_sel_t pick_src(
        input logic                   used,
        input rv_isa_pkg::reg_idx_t   idx,
        input logic                   store_data,
        input hazard_pkg::stage_rec_t mem,
        input logic                   mem_load,
        input hazard_pkg::stage_rec_t wb
    );
        hazard_pkg::fwd_sel_t sel;
        sel = hazard_pkg::fwd_none;
        if (!used) begin
            sel = hazard_pkg::fwd_none;
        end else if (store_data && mem_load && !mem.wr_reg_n && (mem.rd == idx)) begin
            // store data is needed only at the memory stage, load data is ready by then
            sel = hazard_pkg::fwd_mem_load;
        end else if (!mem_load && !mem.wr_reg_n && (mem.rd == idx)) begin
            sel = hazard_pkg::fwd_mem;
        end else if (!wb.wr_reg_n && (wb.rd == idx)) begin
            sel = hazard_pkg::fwd_wb;
        end
        return sel;
    endfunction

    // rs1 is an address or ALU input, never store data
    assign fwd.rs1_sel = pick_src(ex_rec.uses_rs1, ex_rec.rs1, 1'b0,
                                  mem_rec, mem_is_load, wb_rec);
    assign fwd.rs2_sel = pick_src(ex_rec.uses_rs2, ex_rec.rs2, ex_is_store,
                                  mem_rec, mem_is_load, wb_rec);

    a_rs1_no_load_fwd: assert property (
        @(posedge clk) disable iff (!arst_n)
            fwd.rs1_sel != hazard_pkg::fwd_mem_load
    ) else $error("rs1 selected the load path from MEM");

    // holds only if the stall detector kept every other load consumer back a cycle
    a_load_use_covered: assert property (
        @(posedge clk) disable iff (!arst_n)
            !(mem_is_load && !mem_rec.wr_reg_n && !ex_is_store
              && ((ex_rec.uses_rs1 && (ex_rec.rs1 == mem_rec.rd))
                  || (ex_rec.uses_rs2 && (ex_rec.rs2 == mem_rec.rd))))
    ) else $error("load result needed in EX while the load is still in MEM");

endmodule

// ==== logic/stage_tracker.sv ====
`timescale 1ns/100ps
`include "hazard_cfg.svh"

module stage_tracker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  hazard_pkg::stage_rec_t id_rec,
    input  logic                   stall,
    output hazard_pkg::stage_rec_t ex_rec,
    output hazard_pkg::stage_rec_t mem_rec,
    output hazard_pkg::stage_rec_t wb_rec
);

    // index 0 is EX, then MEM, then WB
    hazard_pkg::stage_rec_t rec_q [`HAZARD_TRACK_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // empty pipe so nothing can stall or forward
            for (int i = 0; i < `HAZARD_TRACK_DEPTH; i++) begin
                rec_q[i] <= hazard_pkg::bubble_rec;
            end
        end else begin
            // ID holds its word during a stall, so EX gets an empty slot
            if (stall) begin
                rec_q[0] <= hazard_pkg::bubble_rec;
            end else begin
                rec_q[0] <= id_rec;
            end
            // older stages always advance
            for (int i = 1; i < `HAZARD_TRACK_DEPTH; i++) begin
                rec_q[i] <= rec_q[i-1];
            end
        end
    end

    assign ex_rec  = rec_q[0];
    assign mem_rec = rec_q[1];
    assign wb_rec  = rec_q[2];

    // the stalled slot must never carry a write into the later stages
    property p_bubble_after_stall;
        @(posedge clk) disable iff (!arst_n)
            stall |=> ex_rec.wr_reg_n;
    endproperty

    a_bubble_after_stall: assert property (p_bubble_after_stall)
        else $error("EX holds a writing record in the cycle after a stall");

    // the bubble behind a load never stalls, so a stall lasts exactly one cycle
    property p_single_stall;
        @(posedge clk) disable iff (!arst_n)
            stall |=> !stall;
    endproperty

    a_single_stall: assert property (p_single_stall)
        else $error("stall held high for more than one cycle");

endmodule

// ==== logic/stall_detector.sv ====
`timescale 1ns/100ps

module stall_detector (
    // instruction waiting in ID
    input  hazard_pkg::stage_rec_t id_rec,
    // instruction currently in EX
    input  hazard_pkg::stage_rec_t ex_rec,
    output logic                   stall
);

    logic is_load_in_ex;
    logic is_store_in_id;
    logic rs1_updated;
    logic rs2_updated;

    // load result only exists after MEM, one cycle too late for EX
    assign is_load_in_ex = (ex_rec.opcode == rv_isa_pkg::op_load) && !ex_rec.wr_reg_n;
    assign is_store_in_id = (id_rec.opcode == rv_isa_pkg::op_store);

    // use flags replace the x0 tests since the decoder never writes x0
    assign rs1_updated = id_rec.uses_rs1 && (id_rec.rs1 == ex_rec.rd);
    assign rs2_updated = id_rec.uses_rs2 && (id_rec.rs2 == ex_rec.rd);

    assign stall = stall_ctrl(is_load_in_ex, is_store_in_id, rs1_updated, rs2_updated);

    function automatic logic stall_ctrl(
        input logic load_in_ex,
        input logic store_in_id,
        input logic rs1_hit,
        input logic rs2_hit
    );
        logic result;
        result = 1'b0;
        if (!load_in_ex) begin
            // everything else is covered by the forwarding paths
            result = 1'b0;
        end else if (store_in_id) begin
            // store data (rs2) can be picked up from the load in MEM,
            // the address (rs1) cannot
            result = rs1_hit;
        end else begin
            result = rs1_hit || rs2_hit;
        end
        return result;
    endfunction

    // only a load into a real register may hold ID, x0 is filtered by the decoder
    always_comb begin
        assert final (!stall || ((ex_rec.opcode == rv_isa_pkg::op_load) && (ex_rec.rd != '0)))
            else $error("stall raised without a load to a nonzero register in EX");
    end

endmodule

// ==== logic/instr_field_decoder.sv ====
`timescale 1ns/100ps

module instr_field_decoder (
    input  rv_isa_pkg::instr_t      instr,
    input  logic                    valid,
    output hazard_pkg::stage_rec_t  rec
);

    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::reg_idx_t rd;
    logic                 writes_rd;
    logic                 uses_rs1;
    logic                 uses_rs2;

    // fixed RV32I field positions, identical for all formats that have them
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];

    // operand use and write-back by opcode class
    always_comb begin
        writes_rd = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (opcode)
            rv_isa_pkg::op_load,
            rv_isa_pkg::op_op_imm,
            rv_isa_pkg::op_jalr: begin
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
            end
            rv_isa_pkg::op_op: begin
                writes_rd = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            // store and branch read both sources and write nothing
            rv_isa_pkg::op_store,
            rv_isa_pkg::op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            // immediate-only producers
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_auipc,
            rv_isa_pkg::op_jal: begin
                writes_rd = 1'b1;
            end
            // unknown opcodes are treated as harmless
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        rec = hazard_pkg::bubble_rec;
        if (valid) begin
            rec.opcode   = opcode;
            rec.rs1      = instr[19:15];
            rec.rs2      = instr[24:20];
            rec.rd       = rd;
            // a write to x0 is dropped here so no later stage has to test for it
            rec.wr_reg_n = !(writes_rd && (rd != '0));
            rec.uses_rs1 = uses_rs1;
            rec.uses_rs2 = uses_rs2;
        end
    end

endmodule

// ==== logic/hazard_pkg.sv ====
package hazard_pkg;

    // decoded view of one instruction as it moves down the pipe
    typedef struct packed {
        rv_isa_pkg::opcode_t  opcode;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        // low when the instruction writes rd (never for x0)
        logic                 wr_reg_n;
        logic                 uses_rs1;
        logic                 uses_rs2;
    } stage_rec_t;

    // empty slot, writes nothing and reads nothing
    localparam stage_rec_t bubble_rec = '{
        opcode:   '0,
        rs1:      '0,
        rs2:      '0,
        rd:       '0,
        wr_reg_n: 1'b1,
        uses_rs1: 1'b0,
        uses_rs2: 1'b0
    };

    // operand source for the instruction in EX
    typedef enum logic [1:0] {
        fwd_none     = 2'b00,
        fwd_mem      = 2'b01,
        fwd_wb       = 2'b10,
        fwd_mem_load = 2'b11
    } fwd_sel_t;

    typedef struct packed {
        fwd_sel_t rs1_sel;
        fwd_sel_t rs2_sel;
    } fwd_pair_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
`include "hazard_cfg.svh"

package rv_isa_pkg;

    // raw word as fetched into ID
    typedef logic [`HAZARD_INSTR_W-1:0] instr_t;

    // rs1, rs2 and rd all share this width
    typedef logic [`HAZARD_REG_ADDR_W-1:0] reg_idx_t;

    // major opcode, low seven bits of the word
    typedef logic [`HAZARD_OPCODE_W-1:0] opcode_t;

    // loads, rd <- mem[rs1 + imm]
    localparam opcode_t op_load = 7'b0000011;
    // stores read both rs1 (address) and rs2 (data)
    localparam opcode_t op_store = 7'b0100011;
    // register-register ALU
    localparam opcode_t op_op = 7'b0110011;
    // register-immediate ALU
    localparam opcode_t op_op_imm = 7'b0010011;
    // upper immediate forms read no register
    localparam opcode_t op_lui = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;
    // jal links into rd, reads nothing
    localparam opcode_t op_jal = 7'b1101111;
    // jalr links into rd and reads rs1 for the target
    localparam opcode_t op_jalr = 7'b1100111;
    // branches compare rs1 and rs2, no write
    localparam opcode_t op_branch = 7'b1100011;

endpackage

// ==== logic/hazard_cfg.svh ====
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// architectural register index, x0..x31
`define HAZARD_REG_ADDR_W 5
// full RV32I instruction word
`define HAZARD_INSTR_W 32
// major opcode field in bits 6:0
`define HAZARD_OPCODE_W 7
// shadow stages kept behind ID: EX, MEM, WB
`define HAZARD_TRACK_DEPTH 3

`endif
